// ==== common/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data and address width
`define RV_XLEN         32
`define RV_RESET_PC     32'h0000_0000

// major opcodes
`define RV_OP_IMM       7'b0010011
`define RV_OP_OP        7'b0110011
`define RV_OP_STORE     7'b0100011
`define RV_OP_LOAD      7'b0000011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111

// alu funct3, shared by register and immediate forms
`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL_SRA   3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// load funct3
`define RV_F3_LB        3'b000
`define RV_F3_LH        3'b001
`define RV_F3_LW        3'b010
`define RV_F3_LBU       3'b100
`define RV_F3_LHU       3'b101

// store funct3
`define RV_F3_SB        3'b000
`define RV_F3_SH        3'b001
`define RV_F3_SW        3'b010

// branch funct3
`define RV_F3_BEQ       3'b000
`define RV_F3_BNE       3'b001
`define RV_F3_BLT       3'b100
`define RV_F3_BGE       3'b101
`define RV_F3_BLTU      3'b110
`define RV_F3_BGEU      3'b111

// memory access size
`define RV_SIZE_BYTE    2'd0
`define RV_SIZE_HALF    2'd1
`define RV_SIZE_WORD    2'd2

`endif

// ==== common/rv_pkg.sv ====
`default_nettype none
`include "rv_defines.svh"

package rv_pkg;

    // decoded instruction, operands already selected
    typedef struct packed {
        logic [`RV_XLEN-1:0] op1;
        logic [`RV_XLEN-1:0] op2;
        logic [`RV_XLEN-1:0] jmp_base;
        logic [`RV_XLEN-1:0] jmp_off;
        logic [`RV_XLEN-1:0] rs2_data;
        logic [4:0]          rd;
        logic                rd_wen;
        logic [6:0]          opcode;
        logic [2:0]          funct3;
        logic                funct7_5;
        logic [4:0]          shamt;
    } dec_bundle_t;

    // wdata is still in the low lanes here
    typedef struct packed {
        logic [`RV_XLEN-1:0] addr;
        logic [`RV_XLEN-1:0] wdata;
        logic [1:0]          size;
        logic                ren;
        logic                wen;
        logic                unsigned_ld;
    } mem_req_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic                wen;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                taken;
        logic [`RV_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== core/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] inst_i,
    input  logic [`RV_XLEN-1:0] rs1_data_i,
    input  logic [`RV_XLEN-1:0] rs2_data_i,
    output logic [4:0]          rs1_addr_o,
    output logic [4:0]          rs2_addr_o,
    output dec_bundle_t         dec_o
);

    logic [6:0]          opcode;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign opcode     = inst_i[6:0];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // immediates, all sign extended from bit 31
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    always_comb begin
        dec_o          = '0;
        dec_o.opcode   = opcode;
        dec_o.funct3   = inst_i[14:12];
        dec_o.funct7_5 = inst_i[30];
        dec_o.rd       = inst_i[11:7];
        dec_o.rs2_data = rs2_data_i;
        // register shifts take the amount from rs2
        dec_o.shamt    = (opcode == `RV_OP_OP) ? rs2_data_i[4:0] : inst_i[24:20];

        case (opcode)
            `RV_OP_IMM, `RV_OP_LOAD: begin
                dec_o.op1    = rs1_data_i;
                dec_o.op2    = imm_i;
                dec_o.rd_wen = 1'b1;
            end
            `RV_OP_STORE: begin
                dec_o.op1 = rs1_data_i;
                dec_o.op2 = imm_s;
            end
            `RV_OP_OP: begin
                dec_o.op1    = rs1_data_i;
                dec_o.op2    = rs2_data_i;
                dec_o.rd_wen = 1'b1;
            end
            `RV_OP_BRANCH: begin
                dec_o.op1      = rs1_data_i;
                dec_o.op2      = rs2_data_i;
                dec_o.jmp_base = pc_i;
                dec_o.jmp_off  = imm_b;
            end
            `RV_OP_LUI: begin
                dec_o.op2    = imm_u;
                dec_o.rd_wen = 1'b1;
            end
            `RV_OP_AUIPC: begin
                dec_o.op1    = pc_i;
                dec_o.op2    = imm_u;
                dec_o.rd_wen = 1'b1;
            end
            // link value is pc + 4
            `RV_OP_JAL: begin
                dec_o.op1      = pc_i;
                dec_o.op2      = 32'd4;
                dec_o.jmp_base = pc_i;
                dec_o.jmp_off  = imm_j;
                dec_o.rd_wen   = 1'b1;
            end
            `RV_OP_JALR: begin
                dec_o.op1      = pc_i;
                dec_o.op2      = 32'd4;
                dec_o.jmp_base = rs1_data_i;
                dec_o.jmp_off  = imm_i;
                dec_o.rd_wen   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== core/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_execute
    import rv_pkg::*;
(
    input  dec_bundle_t         dec_i,
    input  logic                valid_i,
    input  logic [`RV_XLEN-1:0] ld_data_i,
    output mem_req_t            mem_req_o,
    output redirect_t           redirect_o,
    output wb_t                 wb_o
);

    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] jmp_target;
    logic                br_taken;
    logic [`RV_XLEN-1:0] wb_data;
    mem_req_t            req;
    redirect_t           redir;

    // also the load/store address and the link value
    assign sum        = dec_i.op1 + dec_i.op2;
    assign jmp_target = dec_i.jmp_base + dec_i.jmp_off;

    // alu for register and immediate forms
    always_comb begin
        alu_res = '0;
        case (dec_i.funct3)
            `RV_F3_ADD_SUB: begin
                // only the register form can subtract
                if ((dec_i.opcode == `RV_OP_OP) && dec_i.funct7_5) begin
                    alu_res = dec_i.op1 - dec_i.op2;
                end else begin
                    alu_res = sum;
                end
            end
            `RV_F3_SLT: begin
                alu_res = ($signed(dec_i.op1) < $signed(dec_i.op2)) ? 32'd1 : 32'd0;
            end
            `RV_F3_SLTU: begin
                alu_res = (dec_i.op1 < dec_i.op2) ? 32'd1 : 32'd0;
            end
            `RV_F3_XOR: alu_res = dec_i.op1 ^ dec_i.op2;
            `RV_F3_OR:  alu_res = dec_i.op1 | dec_i.op2;
            `RV_F3_AND: alu_res = dec_i.op1 & dec_i.op2;
            `RV_F3_SLL: alu_res = dec_i.op1 << dec_i.shamt;
            `RV_F3_SRL_SRA: begin
                if (dec_i.funct7_5) begin
                    alu_res = $signed(dec_i.op1) >>> dec_i.shamt;
                end else begin
                    alu_res = dec_i.op1 >> dec_i.shamt;
                end
            end
            default: ;
        endcase
    end

    // branch compare
    always_comb begin
        case (dec_i.funct3)
            `RV_F3_BEQ:  br_taken = (dec_i.op1 == dec_i.op2);
            `RV_F3_BNE:  br_taken = (dec_i.op1 != dec_i.op2);
            `RV_F3_BLT:  br_taken = ($signed(dec_i.op1) < $signed(dec_i.op2));
            `RV_F3_BGE:  br_taken = ($signed(dec_i.op1) >= $signed(dec_i.op2));
            `RV_F3_BLTU: br_taken = (dec_i.op1 < dec_i.op2);
            `RV_F3_BGEU: br_taken = (dec_i.op1 >= dec_i.op2);
            default:     br_taken = 1'b0;
        endcase
    end

    always_comb begin
        req       = '0;
        req.addr  = sum;
        req.wdata = dec_i.rs2_data;
        redir     = '0;
        wb_data   = '0;

        case (dec_i.opcode)
            `RV_OP_IMM, `RV_OP_OP: wb_data = alu_res;
            `RV_OP_LOAD: begin
                wb_data = ld_data_i;
                req.ren = 1'b1;
                case (dec_i.funct3)
                    `RV_F3_LB:  req.size = `RV_SIZE_BYTE;
                    `RV_F3_LH:  req.size = `RV_SIZE_HALF;
                    `RV_F3_LW:  req.size = `RV_SIZE_WORD;
                    `RV_F3_LBU: begin
                        req.size        = `RV_SIZE_BYTE;
                        req.unsigned_ld = 1'b1;
                    end
                    `RV_F3_LHU: begin
                        req.size        = `RV_SIZE_HALF;
                        req.unsigned_ld = 1'b1;
                    end
                    default: req.ren = 1'b0;
                endcase
            end
            `RV_OP_STORE: begin
                req.wen = 1'b1;
                case (dec_i.funct3)
                    `RV_F3_SB: req.size = `RV_SIZE_BYTE;
                    `RV_F3_SH: req.size = `RV_SIZE_HALF;
                    `RV_F3_SW: req.size = `RV_SIZE_WORD;
                    default:   req.wen  = 1'b0;
                endcase
            end
            `RV_OP_BRANCH: begin
                redir.taken  = br_taken;
                redir.target = jmp_target;
            end
            `RV_OP_LUI, `RV_OP_AUIPC: wb_data = sum;
            `RV_OP_JAL: begin
                wb_data      = sum;
                redir.taken  = 1'b1;
                redir.target = jmp_target;
            end
            `RV_OP_JALR: begin
                wb_data      = sum;
                redir.taken  = 1'b1;
                redir.target = {jmp_target[`RV_XLEN-1:1], 1'b0};
            end
            default: ;
        endcase
    end

    // nothing leaves the core before fetch is valid
    always_comb begin
        mem_req_o        = req;
        mem_req_o.wen    = req.wen & valid_i;
        redirect_o       = redir;
        redirect_o.taken = redir.taken & valid_i;
        wb_o.rd          = dec_i.rd;
        wb_o.wen         = dec_i.rd_wen & valid_i;
        wb_o.data        = wb_data;
    end

    always_comb begin
        if (redirect_o.taken) begin
            a_target_even: assert (redirect_o.target[0] == 1'b0)
                else $error("taken redirect with odd target %h", redirect_o.target);
        end
    end

endmodule

`default_nettype wire

// ==== core/rv_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  redirect_t           redirect_i,
    output logic [`RV_XLEN-1:0] pc_o,
    output logic                valid_o
);

    logic [`RV_XLEN-1:0] pc_next;

    assign pc_next = redirect_i.taken ? redirect_i.target : pc_o + 32'd4;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o    <= `RV_RESET_PC;
            valid_o <= 1'b0;
        end else begin
            valid_o <= 1'b1;
            // hold reset pc until its instruction has run once
            if (valid_o) begin
                pc_o <= pc_next;
            end
        end
    end

    // target comes from execute, fetch relies on word alignment
    a_redirect_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_i.taken |-> (redirect_i.target[1:0] == 2'b00))
        else $error("taken redirect to unaligned target %h", redirect_i.target);

endmodule

`default_nettype wire

// ==== core/rv_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_lsu
    import rv_pkg::*;
(
    input  mem_req_t            req_i,
    output logic [`RV_XLEN-1:0] dmem_addr_o,
    output logic                dmem_ren_o,
    output logic                dmem_wen_o,
    output logic [`RV_XLEN-1:0] dmem_wdata_o,
    output logic [3:0]          dmem_wmask_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output logic [`RV_XLEN-1:0] ld_data_o
);

    logic [1:0]          offset;
    logic [3:0]          mask_base;
    logic [`RV_XLEN-1:0] rdata_sh;

    assign offset      = req_i.addr[1:0];
    assign dmem_addr_o = {req_i.addr[`RV_XLEN-1:2], 2'b00};
    assign dmem_ren_o  = req_i.ren;
    assign dmem_wen_o  = req_i.wen;

    always_comb begin
        case (req_i.size)
            `RV_SIZE_BYTE: mask_base = 4'b0001;
            `RV_SIZE_HALF: mask_base = 4'b0011;
            default:       mask_base = 4'b1111;
        endcase
    end

    // move store data and mask up to the addressed lane
    assign dmem_wdata_o = req_i.wdata << {offset, 3'b000};
    assign dmem_wmask_o = mask_base << offset;

    assign rdata_sh = dmem_rdata_i >> {offset, 3'b000};

    always_comb begin
        case (req_i.size)
            `RV_SIZE_BYTE: begin
                ld_data_o = req_i.unsigned_ld ? {24'h0, rdata_sh[7:0]}
                                              : {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            end
            `RV_SIZE_HALF: begin
                ld_data_o = req_i.unsigned_ld ? {16'h0, rdata_sh[15:0]}
                                              : {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            end
            default: ld_data_o = rdata_sh;
        endcase
    end

    // no misaligned accesses reach the bus
    always_comb begin
        if (req_i.ren || req_i.wen) begin
            if (req_i.size == `RV_SIZE_HALF) begin
                a_half_aligned: assert (req_i.addr[0] == 1'b0)
                    else $error("misaligned half access at %h", req_i.addr);
            end
            if (req_i.size == `RV_SIZE_WORD) begin
                a_word_aligned: assert (req_i.addr[1:0] == 2'b00)
                    else $error("misaligned word access at %h", req_i.addr);
            end
        end
    end

endmodule

`default_nettype wire

// ==== core/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_regfile
    import rv_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [4:0]          rs1_addr_i,
    input  logic [4:0]          rs2_addr_i,
    output logic [`RV_XLEN-1:0] rs1_data_o,
    output logic [`RV_XLEN-1:0] rs2_data_o,
    input  wb_t                 wb_i
);

    // x0 has no storage
    logic [`RV_XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.wen && (wb_i.rd != 5'd0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

    a_x0_rs1_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs1_addr_i == 5'd0) |-> (rs1_data_o == '0));
    a_x0_rs2_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (rs2_addr_i == 5'd0) |-> (rs2_data_o == '0));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_top -f sources.f

./obj_dir/Vtb_top | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"

// ==== sources.f ====
+incdir+common
common/rv_pkg.sv
core/rv_fetch.sv
core/rv_regfile.sv
core/rv_decode.sv
core/rv_execute.sv
core/rv_lsu.sv
verilog/rv_core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== testbench/core_cases.txt ====
# P byte_addr word | D byte_addr word | S name byte_addr data mask
P 00000000 FFB00093
P 00000004 00300113
P 00000008 002081B3
P 0000000C 10302023
P 00000010 40110233
P 00000014 0020A2B3
P 00000018 0020B333
P 0000001C 0020C3B3
P 00000020 10402223
P 00000024 10502423
P 00000028 10602623
P 0000002C 10702823
P 00000030 4020D433
P 00000034 01F0D493
P 00000038 01F11513
P 0000003C 10802A23
P 00000040 10902C23
P 00000044 10A02E23
P 00000048 00700013
P 0000004C 12002023
P 00000050 123455B7
P 00000054 67858593
P 00000058 12B008A3
P 0000005C 12B009A3
P 00000060 12B01B23
P 00000064 12B01A23
P 00000068 12B00C23
P 0000006C 12B00D23
P 00000070 20200603
P 00000074 20304683
P 00000078 20201703
P 0000007C 20005783
P 00000080 20002803
P 00000084 14C02023
P 00000088 14D02223
P 0000008C 14E02423
P 00000090 14F02623
P 00000094 15002823
P 00000098 0020C463
P 0000009C 16102023
P 000000A0 0020E463
P 000000A4 16202223
P 000000A8 00209463
P 000000AC 16102023
P 000000B0 0020F463
P 000000B4 16102023
P 000000B8 00208463
P 000000BC 16202423
P 000000C0 0020D463
P 000000C4 16202623
P 000000C8 008008EF
P 000000CC 16102023
P 000000D0 17102823
P 000000D4 0E100967
P 000000D8 16102023
P 000000DC 16102023
P 000000E0 17202A23
P 000000E4 0000006F
D 00000200 80FF7F01
S add 00000100 FFFFFFFE F
S sub 00000104 00000008 F
S slt 00000108 00000001 F
S sltu 0000010C 00000000 F
S xor 00000110 FFFFFFF8 F
S sra 00000114 FFFFFFFF F
S srli 00000118 00000001 F
S slli 0000011C 80000000 F
S x0_write 00000120 00000000 F
S sb_off1 00000130 00007800 2
S sb_off3 00000130 78000000 8
S sh_off2 00000134 56780000 C
S sh_off0 00000134 00005678 3
S sb_off0 00000138 00000078 1
S sb_off2 00000138 00780000 4
S lb 00000140 FFFFFFFF F
S lbu 00000144 00000080 F
S lh 00000148 FFFF80FF F
S lhu 0000014C 00007F01 F
S lw 00000150 80FF7F01 F
S bltu_not_taken 00000164 00000003 F
S beq_not_taken 00000168 00000003 F
S bge_not_taken 0000016C 00000003 F
S jal_link 00000170 000000CC F
S jalr_link 00000174 000000D8 F

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module tb_checker (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic [31:0] inst_addr_i,
    input  logic [31:0] inst_i,
    input  logic        dmem_ren_i,
    input  logic        dmem_wen_i,
    input  logic [31:0] dmem_addr_i,
    input  logic [31:0] dmem_wdata_i,
    input  logic [3:0]  dmem_wmask_i,
    output int          n_exp_o,
    output int          seen_o,
    output int          err_count_o
);

    string       exp_name [64];
    logic [31:0] exp_addr [64];
    logic [31:0] exp_data [64];
    logic [3:0]  exp_mask [64];
    int          n_exp = 0;
    int          seen = 0;
    int          err_count = 0;
    int          run_cycles = 0;

    assign n_exp_o     = n_exp;
    assign seen_o      = seen;
    assign err_count_o = err_count;

    task automatic add_expected(input string name, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] mask);
        exp_name[n_exp] = name;
        exp_addr[n_exp] = addr;
        exp_data[n_exp] = data;
        exp_mask[n_exp] = mask;
        n_exp++;
    endtask

    // only loads read the data port
    task automatic check_read_enable();
        logic exp_ren;
        exp_ren = (inst_i[6:0] == `RV_OP_LOAD);
        if (dmem_ren_i !== exp_ren) begin
            $display("Mismatch dmem_ren at pc %h: expected %b actual %b",
                     inst_addr_i, exp_ren, dmem_ren_i);
            err_count++;
        end
    endtask

    task automatic compare_store();
        logic [31:0] lanes;
        if (seen >= n_exp) begin
            $display("unexpected write to address %h with data %h and mask %h",
                     dmem_addr_i, dmem_wdata_i, dmem_wmask_i);
            err_count++;
        end else begin
            // bytes outside the mask never reach memory
            for (int b = 0; b < 4; b++) begin
                lanes[b*8 +: 8] = {8{exp_mask[seen][b]}};
            end
            if (dmem_addr_i !== exp_addr[seen] || dmem_wmask_i !== exp_mask[seen]
                    || (dmem_wdata_i & lanes) !== (exp_data[seen] & lanes)) begin
                $display("Mismatch %s: expected addr %h data %h mask %h actual addr %h data %h mask %h",
                         exp_name[seen], exp_addr[seen], exp_data[seen], exp_mask[seen],
                         dmem_addr_i, dmem_wdata_i, dmem_wmask_i);
                err_count++;
            end
            seen++;
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            run_cycles = 0;
            if (dmem_wen_i) begin
                $display("data write to %h while reset is asserted", dmem_addr_i);
                err_count++;
            end
        end else begin
            check_read_enable();
            if (run_cycles == 0) begin
                // release cycle, core must still be quiet
                run_cycles = 1;
                if (dmem_wen_i) begin
                    $display("data write to %h in the reset release cycle", dmem_addr_i);
                    err_count++;
                end
                if (inst_addr_i !== `RV_RESET_PC) begin
                    $display("Mismatch reset_pc: expected %h actual %h",
                             `RV_RESET_PC, inst_addr_i);
                    err_count++;
                end
            end else if (dmem_wen_i) begin
                compare_store();
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module tb_top;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] inst_addr_o;
    logic [31:0] inst_i;
    logic [31:0] dmem_addr_o;
    logic        dmem_ren_o;
    logic [31:0] dmem_rdata_i;
    logic        dmem_wen_o;
    logic [31:0] dmem_wdata_o;
    logic [3:0]  dmem_wmask_o;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    int          n_exp;
    int          seen;
    int          chk_errors;
    int          missing;
    int          cycles;
    int          load_errors;

    rv_core_top rv_core_top_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_addr_o  (inst_addr_o),
        .inst_i       (inst_i),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_ren_o   (dmem_ren_o),
        .dmem_rdata_i (dmem_rdata_i),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_wmask_o (dmem_wmask_o)
    );

    tb_checker tb_checker_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .inst_addr_i  (inst_addr_o),
        .inst_i       (inst_i),
        .dmem_ren_i   (dmem_ren_o),
        .dmem_wen_i   (dmem_wen_o),
        .dmem_addr_i  (dmem_addr_o),
        .dmem_wdata_i (dmem_wdata_o),
        .dmem_wmask_i (dmem_wmask_o),
        .n_exp_o      (n_exp),
        .seen_o       (seen),
        .err_count_o  (chk_errors)
    );

    // both memories answer in the same cycle
    assign inst_i       = imem[inst_addr_o[9:2]];
    assign dmem_rdata_i = dmem[dmem_addr_o[9:2]];

    always @(posedge clk_i) begin
        if (dmem_wen_o) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask_o[b]) begin
                    dmem[dmem_addr_o[9:2]][b*8 +: 8] <= dmem_wdata_o[b*8 +: 8];
                end
            end
        end
    end

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        string       kind;
        string       name;
        logic [31:0] addr;
        logic [31:0] word;
        logic [3:0]  mask;
        fd = $fopen("testbench/core_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file testbench/core_cases.txt");
            load_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s", kind);
                    if (kind == "P") begin
                        n = $sscanf(line, "%s %h %h", kind, addr, word);
                        imem[addr[9:2]] = word;
                    end else if (kind == "D") begin
                        n = $sscanf(line, "%s %h %h", kind, addr, word);
                        dmem[addr[9:2]] = word;
                    end else if (kind == "S") begin
                        n = $sscanf(line, "%s %s %h %h %h", kind, name, addr, word, mask);
                        tb_checker_i.add_expected(name, addr, word, mask);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        rst_n_i     = 1'b0;
        load_errors = 0;
        missing     = 0;
        cycles      = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0000;
            // fill tagged with the byte address
            dmem[i] = 32'hDA7A_0000 ^ (32'(i) << 2);
        end
        load_cases();

        repeat (2) @(posedge clk_i);
        #0.5 rst_n_i = 1'b1;

        while (seen < n_exp && cycles < 2000) begin
            @(posedge clk_i);
            cycles++;
        end
        if (seen < n_exp) begin
            missing = n_exp - seen;
            $display("timeout after %0d cycles, %0d expected stores never arrived",
                     cycles, missing);
        end
        // the self loop must stay quiet
        repeat (10) @(posedge clk_i);

        $display("errors: %0d checker, %0d missing stores, %0d file errors",
                 chk_errors, missing, load_errors);
        if (chk_errors == 0 && missing == 0 && load_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_defines.svh"

module rv_core_top
    import rv_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,
    output logic [`RV_XLEN-1:0] inst_addr_o,
    input  logic [`RV_XLEN-1:0] inst_i,
    output logic [`RV_XLEN-1:0] dmem_addr_o,
    output logic                dmem_ren_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output logic                dmem_wen_o,
    output logic [`RV_XLEN-1:0] dmem_wdata_o,
    output logic [3:0]          dmem_wmask_o
);

    logic                valid;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] ld_data;
    dec_bundle_t         dec;
    mem_req_t            mem_req;
    redirect_t           redirect;
    wb_t                 wb;

    // the pc doubles as the instruction address
    rv_fetch rv_fetch_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect),
        .pc_o       (inst_addr_o),
        .valid_o    (valid)
    );

    rv_regfile rv_regfile_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_i       (wb)
    );

    rv_decode rv_decode_i (
        .pc_i       (inst_addr_o),
        .inst_i     (inst_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .dec_o      (dec)
    );

    rv_execute rv_execute_i (
        .dec_i      (dec),
        .valid_i    (valid),
        .ld_data_i  (ld_data),
        .mem_req_o  (mem_req),
        .redirect_o (redirect),
        .wb_o       (wb)
    );

    rv_lsu rv_lsu_i (
        .req_i        (mem_req),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_ren_o   (dmem_ren_o),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_wmask_o (dmem_wmask_o),
        .dmem_rdata_i (dmem_rdata_i),
        .ld_data_o    (ld_data)
    );

endmodule

`default_nettype wire
